// File: logic/rs_pkg.sv
`default_nettype none

package rs_pkg;

  // Station geometry, one entry per functional unit
  localparam int NUM_FU = 4;

  // Functional-unit kind codes
  localparam int FU_W = 2;

  localparam logic [FU_W-1:0] FU_ALU  = 2'd0;  // Integer ALU
  localparam logic [FU_W-1:0] FU_MULT = 2'd1;  // Multiplier
  localparam logic [FU_W-1:0] FU_MEM  = 2'd2;  // Load/store unit

  // Kind of each entry, entry 0 in the low slot
  localparam logic [NUM_FU-1:0][FU_W-1:0] FU_LIST = {
    FU_MEM,   // Entry 3
    FU_MULT,  // Entry 2
    FU_ALU,   // Entry 1
    FU_ALU    // Entry 0
  };

  // Reorder buffer indexing
  localparam int NUM_ROB = 16;
  localparam int ROB_W   = $clog2(NUM_ROB);  // 4 bits

  // Physical register tags, 32 of them
  localparam int TAG_W = 5;

  // Raw instruction word, carried through untouched
  localparam int INST_W = 32;

endpackage

`default_nettype wire

// File: logic/rob_tail_counter.sv
`default_nettype none

module rob_tail_counter (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     advance,           // Accepted dispatch this cycle
  input  logic                     rollback_en,
  input  logic [rs_pkg::ROB_W-1:0] rollback_rob_idx,  // Oldest index to squash
  output logic [rs_pkg::ROB_W-1:0] tail,
  output logic [rs_pkg::ROB_W-1:0] squash_count
);
  import rs_pkg::*;

  logic [ROB_W-1:0] tail_inc;

  // Next index handed out, wraps at the top of the ROB
  assign tail_inc = (tail == ROB_W'(NUM_ROB - 1)) ? '0 : tail + 1'b1;

  // Span from the rollback point up to the youngest allocated index.
  // Entries whose age relative to rollback_rob_idx falls inside this
  // span are younger than the mispredict and must go.
  assign squash_count = tail - rollback_rob_idx - 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      tail <= '0;
    end else if (rollback_en) begin
      tail <= rollback_rob_idx;  // Reclaim squashed indices
    end else if (advance) begin
      tail <= tail_inc;
    end
  end

  // Dispatch is refused by the station during a rollback
  a_no_advance_on_rollback : assert property (
    @(posedge clock) disable iff (reset)
    !(advance && rollback_en)
  );

endmodule

`default_nettype wire

// File: logic/reservation_station.sv
`default_nettype none

module reservation_station (
  input  logic                                          clock,
  input  logic                                          reset,
  // Dispatch port
  input  logic                                          dispatch_en,
  input  logic [rs_pkg::FU_W-1:0]                       dispatch_fu,
  input  logic [rs_pkg::INST_W-1:0]                     dispatch_inst,
  input  logic [rs_pkg::TAG_W-1:0]                      dispatch_dest_tag,
  input  logic [rs_pkg::TAG_W-1:0]                      src1_tag,
  input  logic [rs_pkg::TAG_W-1:0]                      src2_tag,
  input  logic                                          src1_ready,
  input  logic                                          src2_ready,
  input  logic [rs_pkg::ROB_W-1:0]                      dispatch_rob_idx,
  // Common data bus
  input  logic                                          complete_en,
  input  logic [rs_pkg::TAG_W-1:0]                      cdb_tag,
  // Rollback
  input  logic                                          rollback_en,
  input  logic [rs_pkg::ROB_W-1:0]                      rollback_rob_idx,
  input  logic [rs_pkg::ROB_W-1:0]                      squash_count,
  // Unit availability
  input  logic [rs_pkg::NUM_FU-1:0]                     fu_free,
  output logic                                          dispatch_accept,
  // Issue side, one slot per entry
  output logic [rs_pkg::NUM_FU-1:0]                     issue_ready,
  output logic [rs_pkg::NUM_FU-1:0][rs_pkg::INST_W-1:0] issue_inst,
  output logic [rs_pkg::NUM_FU-1:0][rs_pkg::TAG_W-1:0]  issue_dest_tag,
  output logic [rs_pkg::NUM_FU-1:0][rs_pkg::TAG_W-1:0]  issue_src1_tag,
  output logic [rs_pkg::NUM_FU-1:0][rs_pkg::TAG_W-1:0]  issue_src2_tag,
  output logic [rs_pkg::NUM_FU-1:0][rs_pkg::ROB_W-1:0]  issue_rob_idx
);
  import rs_pkg::*;

  // Entry storage
  logic [NUM_FU-1:0]             busy;
  logic [NUM_FU-1:0][INST_W-1:0] inst_q;
  logic [NUM_FU-1:0][TAG_W-1:0]  dest_tag_q;
  logic [NUM_FU-1:0][TAG_W-1:0]  src1_tag_q;
  logic [NUM_FU-1:0][TAG_W-1:0]  src2_tag_q;
  logic [NUM_FU-1:0]             src1_rdy_q;
  logic [NUM_FU-1:0]             src2_rdy_q;
  logic [NUM_FU-1:0][ROB_W-1:0]  rob_idx_q;

  // Per-entry status for this cycle
  logic [NUM_FU-1:0]             fu_match;    // Entry kind equals dispatch kind
  logic [NUM_FU-1:0]             src1_now;    // Stored or just broadcast
  logic [NUM_FU-1:0]             src2_now;
  logic [NUM_FU-1:0][ROB_W-1:0]  age;         // Distance from rollback point
  logic [NUM_FU-1:0]             squash;
  logic [NUM_FU-1:0]             issuing;
  logic [NUM_FU-1:0]             entry_free;  // Empty or leaving this cycle

  // Allocation
  logic [NUM_FU-1:0]             alloc_vec;   // One-hot first free match
  logic                          alloc_hit;
  logic [NUM_FU-1:0]             write_vec;
  logic                          new_src1_rdy;
  logic                          new_src2_rdy;

  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      fu_match[i]    = FU_LIST[i] == dispatch_fu;
      src1_now[i]    = src1_rdy_q[i] || (complete_en && src1_tag_q[i] == cdb_tag);
      src2_now[i]    = src2_rdy_q[i] || (complete_en && src2_tag_q[i] == cdb_tag);
      age[i]         = rob_idx_q[i] - rollback_rob_idx;
      squash[i]      = rollback_en && busy[i] && (age[i] <= squash_count);
      issue_ready[i] = busy[i] && src1_now[i] && src2_now[i] && !squash[i];
      issuing[i]     = issue_ready[i] && fu_free[i];
      entry_free[i]  = !busy[i] || issuing[i];
    end
  end

  // Priority search in index order
  always_comb begin
    alloc_vec = '0;
    alloc_hit = 1'b0;
    for (int i = 0; i < NUM_FU; i++) begin
      if (!alloc_hit && fu_match[i] && entry_free[i]) begin
        alloc_vec[i] = 1'b1;
        alloc_hit    = 1'b1;
      end
    end
  end

  assign dispatch_accept = alloc_hit && !rollback_en;  // Never during rollback
  assign write_vec       = (dispatch_en && dispatch_accept) ? alloc_vec : '0;

  // Incoming sources also see the broadcast of this cycle
  assign new_src1_rdy = src1_ready || (complete_en && src1_tag == cdb_tag);
  assign new_src2_rdy = src2_ready || (complete_en && src2_tag == cdb_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      for (int i = 0; i < NUM_FU; i++) begin
        if (write_vec[i]) begin
          busy[i] <= 1'b1;
        end else if (issuing[i] || squash[i]) begin
          busy[i] <= 1'b0;  // Issued or squashed
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_FU; i++) begin
      if (write_vec[i]) begin
        inst_q[i]     <= dispatch_inst;
        dest_tag_q[i] <= dispatch_dest_tag;
        src1_tag_q[i] <= src1_tag;
        src2_tag_q[i] <= src2_tag;
        src1_rdy_q[i] <= new_src1_rdy;
        src2_rdy_q[i] <= new_src2_rdy;
        rob_idx_q[i]  <= dispatch_rob_idx;
      end else begin
        // Capture CDB wakeups so readiness sticks
        src1_rdy_q[i] <= src1_now[i];
        src2_rdy_q[i] <= src2_now[i];
      end
    end
  end

  assign issue_inst     = inst_q;
  assign issue_dest_tag = dest_tag_q;
  assign issue_src1_tag = src1_tag_q;
  assign issue_src2_tag = src2_tag_q;
  assign issue_rob_idx  = rob_idx_q;

  // A blocked entry keeps offering itself with the same fields
  // until its unit takes it or a rollback removes it
  for (genvar g = 0; g < NUM_FU; g++) begin : g_hold
    a_ready_held : assert property (
      @(posedge clock) disable iff (reset)
      issue_ready[g] && !fu_free[g] |=> issue_ready[g] || rollback_en
    );

    a_fields_held : assert property (
      @(posedge clock) disable iff (reset)
      issue_ready[g] && !fu_free[g] |=>
        $stable(inst_q[g]) && $stable(dest_tag_q[g]) && $stable(rob_idx_q[g])
    );
  end

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
`default_nettype none

module issue_stage (
  input  logic                                          clock,
  input  logic                                          reset,
  // Dispatch
  input  logic                                          dispatch_en,
  input  logic [rs_pkg::FU_W-1:0]                       dispatch_fu,
  input  logic [rs_pkg::INST_W-1:0]                     dispatch_inst,
  input  logic [rs_pkg::TAG_W-1:0]                      dispatch_dest_tag,
  input  logic [rs_pkg::TAG_W-1:0]                      src1_tag,
  input  logic [rs_pkg::TAG_W-1:0]                      src2_tag,
  input  logic                                          src1_ready,
  input  logic                                          src2_ready,
  // CDB
  input  logic                                          complete_en,
  input  logic [rs_pkg::TAG_W-1:0]                      cdb_tag,
  // Mispredict recovery
  input  logic                                          rollback_en,
  input  logic [rs_pkg::ROB_W-1:0]                      rollback_rob_idx,
  input  logic [rs_pkg::NUM_FU-1:0]                     fu_free,
  output logic                                          dispatch_accept,
  output logic [rs_pkg::ROB_W-1:0]                      dispatch_rob_idx,
  // Issue
  output logic [rs_pkg::NUM_FU-1:0]                     issue_ready,
  output logic [rs_pkg::NUM_FU-1:0][rs_pkg::INST_W-1:0] issue_inst,
  output logic [rs_pkg::NUM_FU-1:0][rs_pkg::TAG_W-1:0]  issue_dest_tag,
  output logic [rs_pkg::NUM_FU-1:0][rs_pkg::TAG_W-1:0]  issue_src1_tag,
  output logic [rs_pkg::NUM_FU-1:0][rs_pkg::TAG_W-1:0]  issue_src2_tag,
  output logic [rs_pkg::NUM_FU-1:0][rs_pkg::ROB_W-1:0]  issue_rob_idx
);
  import rs_pkg::*;

  logic             advance;       // Instruction taken this cycle
  logic [ROB_W-1:0] squash_count;

  assign advance = dispatch_en && dispatch_accept;

  rob_tail_counter u_tail (
    .clock            (clock),
    .reset            (reset),
    .advance          (advance),
    .rollback_en      (rollback_en),
    .rollback_rob_idx (rollback_rob_idx),
    .tail             (dispatch_rob_idx),  // Current tail is the next ROB index
    .squash_count     (squash_count)
  );

  reservation_station u_rs (
    .clock             (clock),
    .reset             (reset),
    .dispatch_en       (dispatch_en),
    .dispatch_fu       (dispatch_fu),
    .dispatch_inst     (dispatch_inst),
    .dispatch_dest_tag (dispatch_dest_tag),
    .src1_tag          (src1_tag),
    .src2_tag          (src2_tag),
    .src1_ready        (src1_ready),
    .src2_ready        (src2_ready),
    .dispatch_rob_idx  (dispatch_rob_idx),
    .complete_en       (complete_en),
    .cdb_tag           (cdb_tag),
    .rollback_en       (rollback_en),
    .rollback_rob_idx  (rollback_rob_idx),
    .squash_count      (squash_count),
    .fu_free           (fu_free),
    .dispatch_accept   (dispatch_accept),
    .issue_ready       (issue_ready),
    .issue_inst        (issue_inst),
    .issue_dest_tag    (issue_dest_tag),
    .issue_src1_tag    (issue_src1_tag),
    .issue_src2_tag    (issue_src2_tag),
    .issue_rob_idx     (issue_rob_idx)
  );

endmodule

`default_nettype wire

// File: dv/issue_stage_vectors.svh
`ifndef ISSUE_STAGE_VECTORS_SVH
`define ISSUE_STAGE_VECTORS_SVH
// Line 1: name, den, fu, inst, dest, s1 tag, s1 rdy, s2 tag, s2 rdy, cen, cdb tag,
//         rollback en, rollback idx, fu_free
// Line 2: accept, rob idx, issue_ready, entry, check fields, inst, dest, s1, s2, entry rob

// MULT dispatch, ready next cycle, leaves on issue
add_row("mult_dispatch", 1, FU_MULT, 'h11110001, 10, 1, 1, 2, 1, 0, 0, 0, 0, 'b0000,
        1, 0, 'b0000, 2, 0, 0, 0, 0, 0, 0);
add_row("mult_ready", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0000,
        1, 1, 'b0100, 2, 1, 'h11110001, 10, 1, 2, 0);
add_row("mult_issue", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0100,
        1, 1, 'b0100, 2, 1, 'h11110001, 10, 1, 2, 0);
add_row("mult_gone", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0000,
        1, 1, 'b0000, 2, 0, 0, 0, 0, 0, 0);

// Two ALU entries fill in order, third waits for entry 0 to issue
add_row("alu_a", 1, FU_ALU, 'h22220001, 11, 3, 1, 4, 1, 0, 0, 0, 0, 'b0000,
        1, 1, 'b0000, 0, 0, 0, 0, 0, 0, 0);
add_row("alu_b", 1, FU_ALU, 'h22220002, 12, 20, 0, 5, 1, 0, 0, 0, 0, 'b0000,
        1, 2, 'b0001, 0, 1, 'h22220001, 11, 3, 4, 1);
add_row("alu_full", 1, FU_ALU, 'h22220003, 13, 6, 1, 7, 1, 0, 0, 0, 0, 'b0000,
        0, 3, 'b0001, 1, 1, 'h22220002, 12, 20, 5, 2);
add_row("alu_retry", 1, FU_ALU, 'h22220003, 13, 6, 1, 7, 1, 0, 0, 0, 0, 'b0001,
        1, 3, 'b0001, 0, 1, 'h22220001, 11, 3, 4, 1);
add_row("alu_c_ready", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0000,
        0, 4, 'b0001, 0, 1, 'h22220003, 13, 6, 7, 3);

// Tag 20 on the CDB wakes entry 1 in the same cycle
add_row("cdb_wake", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 1, 20, 0, 0, 'b0000,
        0, 4, 'b0011, 1, 1, 'h22220002, 12, 20, 5, 2);
add_row("cdb_sticky", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0000,
        0, 4, 'b0011, 1, 1, 'h22220002, 12, 20, 5, 2);
add_row("alu_drain", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0011,
        1, 4, 'b0011, 0, 0, 0, 0, 0, 0, 0);
add_row("mem_cdb_dispatch", 1, FU_MEM, 'h33330001, 14, 21, 0, 22, 0, 1, 21, 0, 0, 'b0000,
        1, 4, 'b0000, 3, 0, 0, 0, 0, 0, 0);
add_row("mem_wait", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0000,
        1, 5, 'b0000, 3, 1, 'h33330001, 14, 21, 22, 4);
add_row("mem_wake_src2", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 1, 22, 0, 0, 'b0000,
        1, 5, 'b1000, 3, 1, 'h33330001, 14, 21, 22, 4);

// Back-pressure on the memory unit
add_row("mem_hold_1", 1, FU_MEM, 'h33330002, 15, 1, 1, 2, 1, 0, 0, 0, 0, 'b0000,
        0, 5, 'b1000, 3, 1, 'h33330001, 14, 21, 22, 4);
add_row("mem_hold_2", 1, FU_MEM, 'h33330002, 15, 1, 1, 2, 1, 0, 0, 0, 0, 'b0000,
        0, 5, 'b1000, 3, 1, 'h33330001, 14, 21, 22, 4);
add_row("mem_hold_3", 1, FU_MEM, 'h33330002, 15, 1, 1, 2, 1, 0, 0, 0, 0, 'b0000,
        0, 5, 'b1000, 3, 1, 'h33330001, 14, 21, 22, 4);
add_row("mem_release", 1, FU_MEM, 'h33330002, 15, 1, 1, 2, 1, 0, 0, 0, 0, 'b1000,
        1, 5, 'b1000, 3, 1, 'h33330001, 14, 21, 22, 4);
add_row("mem_new", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0000,
        1, 6, 'b1000, 3, 1, 'h33330002, 15, 1, 2, 5);
add_row("mem_drain", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b1000,
        1, 6, 'b1000, 3, 0, 0, 0, 0, 0, 0);

// Entries at ROB 3, 4, 5 then rollback to 4
add_row("rewind_tail", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 3, 'b0000,
        0, 6, 'b0000, 0, 0, 0, 0, 0, 0, 0);
add_row("rb_disp_a", 1, FU_ALU, 'h44440003, 16, 1, 1, 2, 1, 0, 0, 0, 0, 'b0000,
        1, 3, 'b0000, 0, 0, 0, 0, 0, 0, 0);
add_row("rb_disp_b", 1, FU_ALU, 'h44440004, 17, 1, 1, 2, 1, 0, 0, 0, 0, 'b0000,
        1, 4, 'b0001, 0, 0, 0, 0, 0, 0, 0);
add_row("rb_disp_c", 1, FU_MULT, 'h44440005, 18, 1, 1, 2, 1, 0, 0, 0, 0, 'b0000,
        1, 5, 'b0011, 0, 0, 0, 0, 0, 0, 0);
add_row("rollback", 1, FU_ALU, 'h44440006, 19, 1, 1, 2, 1, 0, 0, 1, 4, 'b0000,
        0, 6, 'b0001, 0, 1, 'h44440003, 16, 1, 2, 3);
add_row("after_rollback", 1, FU_MULT, 'h44440007, 20, 1, 1, 2, 1, 0, 0, 0, 0, 'b0000,
        1, 4, 'b0001, 0, 1, 'h44440003, 16, 1, 2, 3);
add_row("rb_new_mult", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0000,
        1, 5, 'b0101, 2, 1, 'h44440007, 20, 1, 2, 4);
add_row("rb_drain", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0101,
        1, 5, 'b0101, 0, 0, 0, 0, 0, 0, 0);

// Tail back to 0, then 16 MULT dispatches that wrap it
add_row("wrap_rewind", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 'b0000,
        0, 5, 'b0000, 0, 0, 0, 0, 0, 0, 0);
add_row("wrap_00", 1, FU_MULT, 'h55550000, 0, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 0, 'b0000, 2, 0, 0, 0, 0, 0, 0);
add_row("wrap_01", 1, FU_MULT, 'h55550001, 1, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 1, 'b0100, 2, 1, 'h55550000, 0, 1, 2, 0);
add_row("wrap_02", 1, FU_MULT, 'h55550002, 2, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 2, 'b0100, 2, 1, 'h55550001, 1, 1, 2, 1);
add_row("wrap_03", 1, FU_MULT, 'h55550003, 3, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 3, 'b0100, 2, 1, 'h55550002, 2, 1, 2, 2);
add_row("wrap_04", 1, FU_MULT, 'h55550004, 4, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 4, 'b0100, 2, 1, 'h55550003, 3, 1, 2, 3);
add_row("wrap_05", 1, FU_MULT, 'h55550005, 5, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 5, 'b0100, 2, 1, 'h55550004, 4, 1, 2, 4);
add_row("wrap_06", 1, FU_MULT, 'h55550006, 6, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 6, 'b0100, 2, 1, 'h55550005, 5, 1, 2, 5);
add_row("wrap_07", 1, FU_MULT, 'h55550007, 7, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 7, 'b0100, 2, 1, 'h55550006, 6, 1, 2, 6);
add_row("wrap_08", 1, FU_MULT, 'h55550008, 8, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 8, 'b0100, 2, 1, 'h55550007, 7, 1, 2, 7);
add_row("wrap_09", 1, FU_MULT, 'h55550009, 9, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 9, 'b0100, 2, 1, 'h55550008, 8, 1, 2, 8);
add_row("wrap_10", 1, FU_MULT, 'h5555000a, 10, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 10, 'b0100, 2, 1, 'h55550009, 9, 1, 2, 9);
add_row("wrap_11", 1, FU_MULT, 'h5555000b, 11, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 11, 'b0100, 2, 1, 'h5555000a, 10, 1, 2, 10);
add_row("wrap_12", 1, FU_MULT, 'h5555000c, 12, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 12, 'b0100, 2, 1, 'h5555000b, 11, 1, 2, 11);
add_row("wrap_13", 1, FU_MULT, 'h5555000d, 13, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 13, 'b0100, 2, 1, 'h5555000c, 12, 1, 2, 12);
add_row("wrap_14", 1, FU_MULT, 'h5555000e, 14, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 14, 'b0100, 2, 1, 'h5555000d, 13, 1, 2, 13);
add_row("wrap_15", 1, FU_MULT, 'h5555000f, 15, 1, 1, 2, 1, 0, 0, 0, 0, 'b0100,
        1, 15, 'b0100, 2, 1, 'h5555000e, 14, 1, 2, 14);
add_row("wrap_done", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0100,
        1, 0, 'b0100, 2, 1, 'h5555000f, 15, 1, 2, 15);
add_row("idle_end", 0, FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'b0000,
        1, 0, 'b0000, 2, 0, 0, 0, 0, 0, 0);

`endif

// File: dv/issue_stage_tb.sv
`default_nettype none

module issue_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import rs_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int ENT_W        = $clog2(NUM_FU);
  // Packed row layouts, see add_row for field order
  localparam int STIM_W = 1 + FU_W + INST_W + 4 * TAG_W + 2 + 1 + 1 + ROB_W + NUM_FU;
  localparam int EXP_W  = 1 + ROB_W + NUM_FU + ENT_W + 1 + INST_W + 3 * TAG_W + ROB_W;

  logic                     clock;
  logic                     reset;
  logic                     dispatch_en;
  logic [FU_W-1:0]          dispatch_fu;
  logic [INST_W-1:0]        dispatch_inst;
  logic [TAG_W-1:0]         dispatch_dest_tag;
  logic [TAG_W-1:0]         src1_tag;
  logic [TAG_W-1:0]         src2_tag;
  logic                     src1_ready;
  logic                     src2_ready;
  logic                     complete_en;
  logic [TAG_W-1:0]         cdb_tag;
  logic                     rollback_en;
  logic [ROB_W-1:0]         rollback_rob_idx;
  logic [NUM_FU-1:0]        fu_free;
  logic                     dispatch_accept;
  logic [ROB_W-1:0]         dispatch_rob_idx;
  logic [NUM_FU-1:0]        issue_ready;
  logic [NUM_FU-1:0][INST_W-1:0] issue_inst;
  logic [NUM_FU-1:0][TAG_W-1:0]  issue_dest_tag;
  logic [NUM_FU-1:0][TAG_W-1:0]  issue_src1_tag;
  logic [NUM_FU-1:0][TAG_W-1:0]  issue_src2_tag;
  logic [NUM_FU-1:0][ROB_W-1:0]  issue_rob_idx;

  string             row_name[$];
  logic [STIM_W-1:0] stim_q[$];
  logic [EXP_W-1:0]  expect_q[$];
  bit                rows_loaded = 1'b0;

  issue_stage DUT (
    .clock             (clock),
    .reset             (reset),
    .dispatch_en       (dispatch_en),
    .dispatch_fu       (dispatch_fu),
    .dispatch_inst     (dispatch_inst),
    .dispatch_dest_tag (dispatch_dest_tag),
    .src1_tag          (src1_tag),
    .src2_tag          (src2_tag),
    .src1_ready        (src1_ready),
    .src2_ready        (src2_ready),
    .complete_en       (complete_en),
    .cdb_tag           (cdb_tag),
    .rollback_en       (rollback_en),
    .rollback_rob_idx  (rollback_rob_idx),
    .fu_free           (fu_free),
    .dispatch_accept   (dispatch_accept),
    .dispatch_rob_idx  (dispatch_rob_idx),
    .issue_ready       (issue_ready),
    .issue_inst        (issue_inst),
    .issue_dest_tag    (issue_dest_tag),
    .issue_src1_tag    (issue_src1_tag),
    .issue_src2_tag    (issue_src2_tag),
    .issue_rob_idx     (issue_rob_idx)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic add_row(
    input string           name,
    input int              den,
    input logic [FU_W-1:0] fu,
    input int              inst,
    input int              dest,
    input int              s1_tag,
    input int              s1_rdy,
    input int              s2_tag,
    input int              s2_rdy,
    input int              cen,
    input int              ctag,
    input int              rben,
    input int              rb_idx,
    input int              free,
    input int              exp_accept,
    input int              exp_rob,
    input int              exp_ready,
    input int              entry,
    input int              check_fields,
    input int              exp_inst,
    input int              exp_dest,
    input int              exp_src1,
    input int              exp_src2,
    input int              exp_entry_rob
  );
    row_name.push_back(name);
    stim_q.push_back({1'(den), fu, INST_W'(inst), TAG_W'(dest),
                      TAG_W'(s1_tag), 1'(s1_rdy), TAG_W'(s2_tag), 1'(s2_rdy),
                      1'(cen), TAG_W'(ctag), 1'(rben), ROB_W'(rb_idx), NUM_FU'(free)});
    expect_q.push_back({1'(exp_accept), ROB_W'(exp_rob), NUM_FU'(exp_ready),
                        ENT_W'(entry), 1'(check_fields), INST_W'(exp_inst),
                        TAG_W'(exp_dest), TAG_W'(exp_src1), TAG_W'(exp_src2),
                        ROB_W'(exp_entry_rob)});
  endtask

  task automatic load_table();
    `include "issue_stage_vectors.svh"
  endtask

  task automatic apply_row(input int idx);
    {dispatch_en, dispatch_fu, dispatch_inst, dispatch_dest_tag,
     src1_tag, src1_ready, src2_tag, src2_ready,
     complete_en, cdb_tag, rollback_en, rollback_rob_idx, fu_free} = stim_q[idx];
  endtask

  task automatic check_value(input string row, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s %s: expected %0h, actual %0h", row, field, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "Stopping at first mismatch in row %s", row);
    end
  endtask

  task automatic check_row(input int idx);
    string             name;
    logic              exp_accept;
    logic [ROB_W-1:0]  exp_rob;
    logic [NUM_FU-1:0] exp_ready;
    logic [ENT_W-1:0]  ent;
    logic              chk;
    logic [INST_W-1:0] exp_inst;
    logic [TAG_W-1:0]  exp_dest;
    logic [TAG_W-1:0]  exp_src1;
    logic [TAG_W-1:0]  exp_src2;
    logic [ROB_W-1:0]  exp_entry_rob;
    name = row_name[idx];
    {exp_accept, exp_rob, exp_ready, ent, chk, exp_inst,
     exp_dest, exp_src1, exp_src2, exp_entry_rob} = expect_q[idx];
    check_value(name, "dispatch_accept", 32'(exp_accept), 32'(dispatch_accept));
    check_value(name, "dispatch_rob_idx", 32'(exp_rob), 32'(dispatch_rob_idx));
    check_value(name, "issue_ready", 32'(exp_ready), 32'(issue_ready));
    if (chk) begin  // Fields of the named entry
      check_value(name, $sformatf("issue_inst[%0d]", ent), exp_inst, issue_inst[ent]);
      check_value(name, $sformatf("issue_dest_tag[%0d]", ent),
                  32'(exp_dest), 32'(issue_dest_tag[ent]));
      check_value(name, $sformatf("issue_src1_tag[%0d]", ent),
                  32'(exp_src1), 32'(issue_src1_tag[ent]));
      check_value(name, $sformatf("issue_src2_tag[%0d]", ent),
                  32'(exp_src2), 32'(issue_src2_tag[ent]));
      check_value(name, $sformatf("issue_rob_idx[%0d]", ent),
                  32'(exp_entry_rob), 32'(issue_rob_idx[ent]));
    end
  endtask

  // Budget covers reset, every table row and some slack
  initial begin
    wait (rows_loaded);
    #((row_name.size() + RESET_CYCLES + 10) * CLK_PERIOD);
    $display("Timeout: the stimulus table did not finish within the expected time");
    $display("*** FAILED ***");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    reset = 1'b1;
    {dispatch_en, dispatch_fu, dispatch_inst, dispatch_dest_tag,
     src1_tag, src1_ready, src2_tag, src2_ready,
     complete_en, cdb_tag, rollback_en, rollback_rob_idx, fu_free} = '0;
    load_table();
    rows_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < row_name.size(); i++) begin
      apply_row(i);                  // Falling edge
      #(CLK_PERIOD / 2 - 1);         // Just ahead of the rising edge
      check_row(i);
      @(negedge clock);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+dv
logic/rs_pkg.sv
logic/rob_tail_counter.sv
logic/reservation_station.sv
logic/issue_stage.sv
dv/issue_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module issue_stage_tb \
  -f src.f \
  -Mdir obj_dir

./obj_dir/Vissue_stage_tb | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail, see sim.log"
  exit 1
fi
